// File: Makefile
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
TOP             ?= tb_game_top
FILELIST        ?= filelist.f
BUILD_DIR       ?= obj_dir
PASS_TEXT       := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulation passes only if the pass message shows up in its output.
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: collision_detector.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module collision_detector
(
    input  logic                              clk,
    input  logic                              reset,
    input  sprite_geometry_pkg::sprite_pos_t  target_pos,
    input  sprite_geometry_pkg::sprite_pos_t  torpedo_pos,
    output logic                              collision
);

    int target_x;
    int target_y;
    int torpedo_x;
    int torpedo_y;
    logic overlap_x;
    logic overlap_y;

    assign target_x  = int'(target_pos.x);
    assign target_y  = int'(target_pos.y);
    assign torpedo_x = int'(torpedo_pos.x);
    assign torpedo_y = int'(torpedo_pos.y);

    // Two equal boxes overlap on an axis when each starts before the other ends.
    assign overlap_x = (target_x < torpedo_x + `SPRITE_SIZE) && (torpedo_x < target_x + `SPRITE_SIZE);
    assign overlap_y = (target_y < torpedo_y + `SPRITE_SIZE) && (torpedo_y < target_y + `SPRITE_SIZE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= overlap_x && overlap_y;  // one cycle behind the positions.
    end

endmodule

`default_nettype wire

// File: end_of_game_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module end_of_game_timer
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic running
);

    typedef logic [$clog2(`END_TIMER_CYCLES + 1) - 1:0] hold_count_t;

    hold_count_t count;

    assign running = (count != '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= hold_count_t'(`END_TIMER_CYCLES);  // a new start reloads the full time.
        else if (running)
            count <= count - 1'b1;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
sprite_geometry_pkg.sv
game_control_pkg.sv
frame_tick_gen.sv
sprite_mover.sv
collision_detector.sv
end_of_game_timer.sv
game_master_fsm.sv
game_top.sv
tb_game_top.sv

// File: frame_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module frame_tick_gen
(
    input  logic clk,
    input  logic reset,
    output logic frame_tick
);

    localparam int count_bits = (`FRAME_CYCLES > 1) ? $clog2(`FRAME_CYCLES) : 1;

    typedef logic [count_bits - 1:0] frame_count_t;

    frame_count_t count;

    assign frame_tick = (count == frame_count_t'(`FRAME_CYCLES - 1));  // last cycle of the frame.

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (frame_tick)
            count <= '0;
        else
            count <= count + 1'b1;
    end

endmodule

`default_nettype wire

// File: game_control_pkg.sv
`default_nettype none

// Types used between the game master and the blocks it controls.
package game_control_pkg;

    // Round sequence of the game master.
    typedef enum logic [1:0]
    {
        state_start,   // load start positions and target velocity.
        state_aim,     // target moves, waiting for launch.
        state_shoot,   // both sprites move.
        state_end      // result is held while the end timer runs.
    } game_state_t;

    // One-cycle command pulses to a sprite mover.
    typedef struct packed
    {
        logic write_xy;       // load the start position.
        logic write_dxy;      // load the velocity.
        logic enable_update;  // step the position on a frame tick.
    } sprite_ctrl_t;

endpackage

`default_nettype wire

// File: game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Screen and sprite geometry in pixels.
`define SCREEN_WIDTH      64
`define SCREEN_HEIGHT     48
`define COORD_BITS        7     // signed, so one bit more than the screen needs.
`define SPRITE_SIZE       4     // square sprite box, same on both axes.

// Target enters at the left edge and crosses the screen.
`define TARGET_START_X    0
`define TARGET_START_Y    8
`define TARGET_DX         (1)

// Torpedo waits at the bottom until launched, then rises.
`define TORPEDO_START_X   30
`define TORPEDO_START_Y   44
`define TORPEDO_DY        (-1)

// Game pacing in clock cycles.
`define FRAME_CYCLES      4
`define END_TIMER_CYCLES  32

`endif

// File: game_master_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_master_fsm
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            launch_key,
    output game_control_pkg::sprite_ctrl_t  target_ctrl,
    output game_control_pkg::sprite_ctrl_t  torpedo_ctrl,
    input  logic                            target_within_screen,
    input  logic                            torpedo_within_screen,
    input  logic                            collision,
    input  logic                            timer_running,
    output logic                            timer_start,
    output logic                            game_won
);

    game_control_pkg::game_state_t  state;
    game_control_pkg::game_state_t  state_next;
    game_control_pkg::sprite_ctrl_t target_ctrl_next;
    game_control_pkg::sprite_ctrl_t torpedo_ctrl_next;
    logic timer_start_next;
    logic game_won_next;
    logic sprite_lost;

    assign sprite_lost = !target_within_screen || !torpedo_within_screen;

    always_comb
    begin
        state_next        = state;
        target_ctrl_next  = '0;
        torpedo_ctrl_next = '0;
        timer_start_next  = 1'b0;
        game_won_next     = game_won;

        case (state)
            game_control_pkg::state_start:
            begin
                game_won_next = 1'b0;
                // the write pulses reach the movers a cycle late, so wait until
                // they are out before aiming with the fresh positions.
                if (!target_ctrl.write_xy)
                begin
                    target_ctrl_next.write_xy  = 1'b1;
                    target_ctrl_next.write_dxy = 1'b1;
                    torpedo_ctrl_next.write_xy = 1'b1;
                end
                else
                    state_next = game_control_pkg::state_aim;
            end

            game_control_pkg::state_aim:
            begin
                target_ctrl_next.enable_update = 1'b1;
                // collisions count only once the torpedo is on its way.
                if (sprite_lost)
                begin
                    timer_start_next = 1'b1;
                    state_next       = game_control_pkg::state_end;
                end
                else if (launch_key)
                    state_next = game_control_pkg::state_shoot;
            end

            game_control_pkg::state_shoot:
            begin
                torpedo_ctrl_next.write_dxy     = 1'b1;
                target_ctrl_next.enable_update  = 1'b1;
                torpedo_ctrl_next.enable_update = 1'b1;
                if (collision)
                    game_won_next = 1'b1;
                if (sprite_lost || collision)
                begin
                    timer_start_next = 1'b1;
                    state_next       = game_control_pkg::state_end;
                end
            end

            game_control_pkg::state_end:
            begin
                if (collision)
                    game_won_next = 1'b1;  // a hit seen late still wins the round.
                // timer_start is still out on the first cycle here, before the timer runs.
                if (!timer_running && !timer_start)
                    state_next = game_control_pkg::state_start;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= game_control_pkg::state_start;
            target_ctrl  <= '0;
            torpedo_ctrl <= '0;
            timer_start  <= 1'b0;
            game_won     <= 1'b0;
        end
        else
        begin
            state        <= state_next;
            target_ctrl  <= target_ctrl_next;
            torpedo_ctrl <= torpedo_ctrl_next;
            timer_start  <= timer_start_next;
            game_won     <= game_won_next;
        end
    end

endmodule

`default_nettype wire

// File: game_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module game_top
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              launch_key,
    output sprite_geometry_pkg::sprite_pos_t  target_pos,
    output sprite_geometry_pkg::sprite_pos_t  torpedo_pos,
    output logic                              game_won,
    output logic                              round_over
);

    game_control_pkg::sprite_ctrl_t target_ctrl;
    game_control_pkg::sprite_ctrl_t torpedo_ctrl;
    logic frame_tick;
    logic target_within_screen;
    logic torpedo_within_screen;
    logic collision;
    logic timer_start;
    logic timer_running;

    assign round_over = timer_running;  // high while the round result is held.

    frame_tick_gen i_frame_tick_gen
    (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick)
    );

    sprite_mover
    #(
        .start_x (sprite_geometry_pkg::coord_t'(`TARGET_START_X)),
        .start_y (sprite_geometry_pkg::coord_t'(`TARGET_START_Y)),
        .step_dx (sprite_geometry_pkg::velocity_t'(`TARGET_DX)),
        .step_dy (sprite_geometry_pkg::velocity_t'(0))
    )
    i_target_mover
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (target_ctrl),
        .frame_tick    (frame_tick),
        .pos           (target_pos),
        .within_screen (target_within_screen)
    );

    sprite_mover
    #(
        .start_x (sprite_geometry_pkg::coord_t'(`TORPEDO_START_X)),
        .start_y (sprite_geometry_pkg::coord_t'(`TORPEDO_START_Y)),
        .step_dx (sprite_geometry_pkg::velocity_t'(0)),
        .step_dy (sprite_geometry_pkg::velocity_t'(`TORPEDO_DY))
    )
    i_torpedo_mover
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (torpedo_ctrl),
        .frame_tick    (frame_tick),
        .pos           (torpedo_pos),
        .within_screen (torpedo_within_screen)
    );

    collision_detector i_collision_detector
    (
        .clk         (clk),
        .reset       (reset),
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .collision   (collision)
    );

    end_of_game_timer i_end_of_game_timer
    (
        .clk     (clk),
        .reset   (reset),
        .start   (timer_start),
        .running (timer_running)
    );

    game_master_fsm i_game_master_fsm
    (
        .clk                   (clk),
        .reset                 (reset),
        .launch_key            (launch_key),
        .target_ctrl           (target_ctrl),
        .torpedo_ctrl          (torpedo_ctrl),
        .target_within_screen  (target_within_screen),
        .torpedo_within_screen (torpedo_within_screen),
        .collision             (collision),
        .timer_running         (timer_running),
        .timer_start           (timer_start),
        .game_won              (game_won)
    );

endmodule

`default_nettype wire

// File: sprite_geometry_pkg.sv
`default_nettype none

`include "game_defines.svh"

// Types that describe where a sprite is and how it moves.
package sprite_geometry_pkg;

    // Signed so that a sprite leaving by the left or top edge
    // shows up as a negative coordinate.
    typedef logic signed [`COORD_BITS - 1:0] coord_t;

    typedef logic signed [1:0] velocity_t;  // step per frame, -2 to +1.

    // Top left corner of the sprite box.
    typedef struct packed
    {
        coord_t x;
        coord_t y;
    } sprite_pos_t;

endpackage

`default_nettype wire

// File: sprite_mover.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module sprite_mover
#(
    parameter sprite_geometry_pkg::coord_t    start_x = '0,
    parameter sprite_geometry_pkg::coord_t    start_y = '0,
    parameter sprite_geometry_pkg::velocity_t step_dx = '0,
    parameter sprite_geometry_pkg::velocity_t step_dy = '0
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  game_control_pkg::sprite_ctrl_t    ctrl,
    input  logic                              frame_tick,
    output sprite_geometry_pkg::sprite_pos_t  pos,
    output logic                              within_screen
);

    sprite_geometry_pkg::velocity_t vel_dx;
    sprite_geometry_pkg::velocity_t vel_dy;

    // Box edges in full integer range, so the test cannot wrap at the screen border.
    int x_left;
    int y_top;
    logic x_inside;
    logic y_inside;

    assign x_left = int'(pos.x);  // sign extended.
    assign y_top  = int'(pos.y);

    assign x_inside = (x_left >= 0) && (x_left + `SPRITE_SIZE <= `SCREEN_WIDTH);
    assign y_inside = (y_top >= 0) && (y_top + `SPRITE_SIZE <= `SCREEN_HEIGHT);

    assign within_screen = x_inside && y_inside;  // whole box must be visible.

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pos.x <= start_x;
            pos.y <= start_y;
        end
        else if (ctrl.write_xy)
        begin
            pos.x <= start_x;
            pos.y <= start_y;
        end
        else if (ctrl.enable_update && frame_tick)
        begin
            // the velocity is signed, so the cast sign extends it.
            pos.x <= pos.x + sprite_geometry_pkg::coord_t'(vel_dx);
            pos.y <= pos.y + sprite_geometry_pkg::coord_t'(vel_dy);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            vel_dx <= '0;  // a sprite stands still until told to move.
            vel_dy <= '0;
        end
        else if (ctrl.write_dxy)
        begin
            vel_dx <= step_dx;
            vel_dy <= step_dy;
        end
    end

endmodule

`default_nettype wire

// File: tb_game_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module tb_game_top;

    localparam int num_rounds  = 8;
    localparam int clk_period  = 8;
    localparam int margin      = 64;
    localparam int watchdog_ns = clk_period * (10 + num_rounds
        * (`SCREEN_WIDTH * `FRAME_CYCLES + `END_TIMER_CYCLES + margin));

    typedef struct packed
    {
        logic won;
        logic target_left;
        logic torpedo_left;
        int   end_x;  // target x when the round ends.
        int   end_y;  // torpedo y when the round ends.
    } round_result_t;

    logic clk;
    logic reset;
    logic launch_key;
    sprite_geometry_pkg::sprite_pos_t target_pos;
    sprite_geometry_pkg::sprite_pos_t torpedo_pos;
    logic game_won;
    logic round_over;

    int seed = 32'hac8d;
    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int rounds_done = 0;
    logic launch_sent = 1'b0;
    round_result_t expected_q[$];
    int launch_q[$];

    game_top i_game_top
    (
        .clk         (clk),
        .reset       (reset),
        .launch_key  (launch_key),
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .game_won    (game_won),
        .round_over  (round_over)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic int coord_value(input sprite_geometry_pkg::coord_t c);
        return int'(c);  // sign extended.
    endfunction

    function automatic bit sprites_at_start();
        return coord_value(target_pos.x) == `TARGET_START_X
            && coord_value(target_pos.y) == `TARGET_START_Y
            && coord_value(torpedo_pos.x) == `TORPEDO_START_X
            && coord_value(torpedo_pos.y) == `TORPEDO_START_Y;
    endfunction

    // Steps both sprites one frame at a time. The key goes down right after
    // the target's step number launch_frame + 1, and the torpedo moves from the next step.
    function automatic round_result_t predict_round(input int launch_frame);
        round_result_t result;
        int tx;
        int ty;
        int px;
        int py;
        int step;
        bit moving;
        result = '0;
        tx = `TARGET_START_X;
        ty = `TARGET_START_Y;
        px = `TORPEDO_START_X;
        py = `TORPEDO_START_Y;
        moving = 1'b0;
        for (step = 1; step <= 4 * `SCREEN_WIDTH; step++)
        begin
            tx += `TARGET_DX;
            if (moving)
                py += `TORPEDO_DY;
            if (step == launch_frame + 1)
                moving = 1'b1;
            result.end_x = tx;
            result.end_y = py;
            if (moving && tx < px + `SPRITE_SIZE && px < tx + `SPRITE_SIZE
                && ty < py + `SPRITE_SIZE && py < ty + `SPRITE_SIZE)
            begin
                result.won = 1'b1;
                return result;
            end
            result.target_left = tx < 0 || tx + `SPRITE_SIZE > `SCREEN_WIDTH;
            result.torpedo_left = py < 0 || py + `SPRITE_SIZE > `SCREEN_HEIGHT;
            if (result.target_left || result.torpedo_left)
                return result;
        end
        return result;
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected)
        else
        begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
            $display("test %0d, %s: ok", test_count, name);
        else
        begin
            failed_tests++;
            $display("test %0d, %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    initial
    begin : stimulus
        int r;
        int launch_frame;
        int launch_x;
        reset = 1'b1;
        launch_key = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (r = 0; r < num_rounds; r++)
        begin
            if (r == 0)
                launch_frame = -1;  // the target crosses alone.
            else if (r == 1)
                launch_frame = 12;
            else
            begin
                launch_frame = $unsigned($random(seed)) % 42;
                if (launch_frame == 41)
                    launch_frame = -1;  // no launch in this round.
            end
            launch_sent = 1'b0;
            launch_q.push_back(launch_frame);
            expected_q.push_back(predict_round(launch_frame));
            launch_x = `TARGET_START_X + (launch_frame + 1) * `TARGET_DX;
            if (launch_frame >= 0)
            begin
                while (coord_value(target_pos.x) != launch_x && !round_over)
                    @(negedge clk);
                if (!round_over)
                begin
                    launch_key = 1'b1;
                    launch_sent = 1'b1;
                    @(negedge clk);
                    launch_key = 1'b0;
                end
            end
            wait (rounds_done == r + 1);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_count, test_count - failed_tests, failed_tests, error_count);
        if (error_count == 0 && failed_tests == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin : compare_rounds
        sprite_geometry_pkg::sprite_pos_t prev_target;
        sprite_geometry_pkg::sprite_pos_t prev_torpedo;
        round_result_t expected;
        string launch_text;
        string outcome_text;
        int r;
        int launch_frame;
        int errors_before;
        int cycle;
        int last_target_move;
        int last_torpedo_move;
        int hold_cycles;
        int wait_cycles;

        @(negedge reset);
        errors_before = error_count;
        repeat (2) @(negedge clk);
        check_value("target_pos.x", coord_value(target_pos.x), `TARGET_START_X);
        check_value("target_pos.y", coord_value(target_pos.y), `TARGET_START_Y);
        check_value("torpedo_pos.x", coord_value(torpedo_pos.x), `TORPEDO_START_X);
        check_value("torpedo_pos.y", coord_value(torpedo_pos.y), `TORPEDO_START_Y);
        check_value("round_over", int'(round_over), 0);
        report_test("start positions after reset", errors_before);

        for (r = 0; r < num_rounds; r++)
        begin
            errors_before = error_count;
            cycle = 0;
            last_target_move = -1;
            last_torpedo_move = -1;
            prev_target = target_pos;
            prev_torpedo = torpedo_pos;
            @(negedge clk);
            while (!round_over)
            begin
                cycle++;
                if (target_pos != prev_target)
                begin
                    check_value("target_pos.x step",
                                coord_value(target_pos.x) - coord_value(prev_target.x),
                                `TARGET_DX);
                    check_value("target_pos.y", coord_value(target_pos.y), `TARGET_START_Y);
                    assert (last_target_move < 0 || cycle - last_target_move == `FRAME_CYCLES)
                    else
                    begin
                        $display("target stepped %0d cycles after its last step",
                                 cycle - last_target_move);
                        error_count++;
                    end
                    last_target_move = cycle;
                end
                if (torpedo_pos != prev_torpedo)
                begin
                    assert (launch_sent)
                    else
                    begin
                        $display("torpedo moved before the launch key was pressed");
                        error_count++;
                    end
                    check_value("torpedo_pos.x", coord_value(torpedo_pos.x), `TORPEDO_START_X);
                    check_value("torpedo_pos.y step",
                                coord_value(torpedo_pos.y) - coord_value(prev_torpedo.y),
                                `TORPEDO_DY);
                    assert (last_torpedo_move < 0 || cycle - last_torpedo_move == `FRAME_CYCLES)
                    else
                    begin
                        $display("torpedo stepped %0d cycles after its last step",
                                 cycle - last_torpedo_move);
                        error_count++;
                    end
                    last_torpedo_move = cycle;
                end
                prev_target = target_pos;
                prev_torpedo = torpedo_pos;
                @(negedge clk);
            end

            // round_over has just risen, so the result must be final now.
            expected = expected_q.pop_front();
            launch_frame = launch_q.pop_front();
            check_value("game_won", int'(game_won), int'(expected.won));
            check_value("target_pos.x", coord_value(target_pos.x), expected.end_x);
            check_value("torpedo_pos.y", coord_value(torpedo_pos.y), expected.end_y);

            hold_cycles = 0;
            while (round_over)
            begin
                hold_cycles++;
                check_value("game_won", int'(game_won), int'(expected.won));
                @(negedge clk);
            end
            assert (hold_cycles == `END_TIMER_CYCLES)
            else
            begin
                $display("round_over was high for %0d cycles instead of %0d",
                         hold_cycles, `END_TIMER_CYCLES);
                error_count++;
            end

            repeat (2) @(negedge clk);
            check_value("game_won", int'(game_won), 0);
            wait_cycles = 0;
            while (!sprites_at_start() && wait_cycles < 4)
            begin
                @(negedge clk);
                wait_cycles++;
            end
            assert (sprites_at_start())
            else
            begin
                $display("sprites did not return to their start positions");
                error_count++;
            end

            if (launch_frame < 0)
                launch_text = "never";
            else
                launch_text = $sformatf("%0d", launch_frame);
            if (expected.won)
                outcome_text = "hit";
            else if (expected.target_left)
                outcome_text = "target left the screen";
            else
                outcome_text = "torpedo left the screen";
            report_test($sformatf("round %0d, launch frame %s, %s", r, launch_text,
                                  outcome_text), errors_before);
            rounds_done++;
        end
    end

    initial
    begin : watchdog
        #(watchdog_ns);
        $display("timeout: the rounds did not finish within %0d ns", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
